// ==== Makefile ====
# Verilator build and run of the bridge testbench

TOP := bridge_tb
SOURCES := $(wildcard hw/*.sv tests/*.sv)

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): all.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -Wall \
		-f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== all.f ====
hw/bridge_pkg.sv
hw/host_addr_xlate.sv
hw/dram_addr_xlate.sv
hw/mem_profiler.sv
hw/csr_regs.sv
hw/bridge_top.sv
tests/bridge_assert.sv
tests/bridge_tb.sv

// ==== hw/bridge_pkg.sv ====
`default_nettype none

package bridge_pkg;

   // processor window address, the PS port drops the top two bits
   typedef logic [29:0] ps_addr_t;

   // core physical address, only the low 32 bits are used on this board
   typedef logic [31:0] bp_addr_t;

   // address into the DRAM allocated by the PS
   typedef logic [31:0] dram_addr_t;

   // register block word and index
   typedef logic [31:0] csr_data_t;
   typedef logic [2:0]  csr_idx_t;

   // one bit per 8 MiB region of core DRAM
   typedef logic [127:0] profile_t;
   typedef logic [6:0]   region_t;

   // start of cached DRAM in the core memory map
   localparam bp_addr_t bp_dram_base = 32'h8000_0000;

   // largest DRAM offset a program is expected to reach (120 MiB)
   localparam dram_addr_t mem_upper_limit = 32'(120 * 1024 * 1024);

   // top bit of the profiler region field in a core address
   localparam int unsigned region_msb = 29;

   // register indices, word addresses on the processor side
   localparam csr_idx_t csr_reset_idx = 3'd0;
   localparam csr_idx_t csr_alloc_idx = 3'd1;
   localparam csr_idx_t csr_base_idx  = 3'd2;

   // profiler words sit at 3 to 6, least significant word first
   localparam csr_idx_t csr_prof0_idx = 3'd3;

endpackage

`default_nettype wire

// ==== hw/bridge_top.sv ====
`default_nettype none

module bridge_top
(
   input  wire                        aclk_i,
   input  wire                        rst_n_i,

   // processor accesses into the core
   input  wire                        host_v_i,
   input  wire                        host_we_i,
   input  wire bridge_pkg::ps_addr_t  host_addr_i,
   output logic                       host_v_o,
   output logic                       host_we_o,
   output bridge_pkg::bp_addr_t       host_addr_o,

   // core requests out to PS dram
   input  wire                        dram_v_i,
   input  wire                        dram_we_i,
   input  wire bridge_pkg::bp_addr_t  dram_addr_i,
   output logic                       dram_v_o,
   output logic                       dram_we_o,
   output bridge_pkg::dram_addr_t     dram_addr_o,
   output logic                       dram_over_limit_o,

   // register block
   input  wire                        csr_we_i,
   input  wire                        csr_re_i,
   input  wire bridge_pkg::csr_idx_t  csr_idx_i,
   input  wire bridge_pkg::csr_data_t csr_wdata_i,
   output logic                       csr_rvalid_o,
   output bridge_pkg::csr_data_t      csr_rdata_o,

   output logic                       bp_reset_o
);

   import bridge_pkg::*;

   csr_data_t dram_base;
   profile_t  profile;
   logic      core_reset;

   host_addr_xlate u_host_addr_xlate
   (
      .aclk_i      (aclk_i),
      .rst_n_i     (rst_n_i),
      .host_v_i    (host_v_i),
      .host_we_i   (host_we_i),
      .host_addr_i (host_addr_i),
      .host_v_o    (host_v_o),
      .host_we_o   (host_we_o),
      .host_addr_o (host_addr_o)
   );

   dram_addr_xlate u_dram_addr_xlate
   (
      .aclk_i            (aclk_i),
      .rst_n_i           (rst_n_i),
      .dram_v_i          (dram_v_i),
      .dram_we_i         (dram_we_i),
      .dram_addr_i       (dram_addr_i),
      .dram_base_i       (dram_base),
      .dram_v_o          (dram_v_o),
      .dram_we_o         (dram_we_o),
      .dram_addr_o       (dram_addr_o),
      .dram_over_limit_o (dram_over_limit_o)
   );

   // sees the core address before translation
   mem_profiler u_mem_profiler
   (
      .aclk_i       (aclk_i),
      .rst_n_i      (rst_n_i),
      .core_reset_i (core_reset),
      .req_v_i      (dram_v_i),
      .req_addr_i   (dram_addr_i),
      .profile_o    (profile)
   );

   csr_regs u_csr_regs
   (
      .aclk_i       (aclk_i),
      .rst_n_i      (rst_n_i),
      .csr_we_i     (csr_we_i),
      .csr_re_i     (csr_re_i),
      .csr_idx_i    (csr_idx_i),
      .csr_wdata_i  (csr_wdata_i),
      .profile_i    (profile),
      .csr_rvalid_o (csr_rvalid_o),
      .csr_rdata_o  (csr_rdata_o),
      .dram_base_o  (dram_base),
      .core_reset_o (core_reset)
   );

   assign bp_reset_o = core_reset;

endmodule

`default_nettype wire

// ==== hw/csr_regs.sv ====
`default_nettype none

module csr_regs
(
   input  wire                        aclk_i,
   input  wire                        rst_n_i,
   input  wire                        csr_we_i,
   input  wire                        csr_re_i,
   input  wire bridge_pkg::csr_idx_t  csr_idx_i,
   input  wire bridge_pkg::csr_data_t csr_wdata_i,
   input  wire bridge_pkg::profile_t  profile_i,
   output logic                       csr_rvalid_o,
   output bridge_pkg::csr_data_t      csr_rdata_o,
   output bridge_pkg::csr_data_t      dram_base_o,
   output logic                       core_reset_o
);

   import bridge_pkg::*;

   csr_data_t reset_r;
   csr_data_t alloc_r;
   csr_data_t base_r;
   csr_data_t rdata_mux;

   // only indices 0 to 2 are writable
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         reset_r <= '0;
         alloc_r <= '0;
         base_r  <= '0;
      end
      else if (csr_we_i)
      begin
         case (csr_idx_i)
            csr_reset_idx: reset_r <= csr_wdata_i;
            csr_alloc_idx: alloc_r <= csr_wdata_i;
            csr_base_idx:  base_r  <= csr_wdata_i;
            default:       ;
         endcase
      end
   end

   always_comb
   begin
      case (csr_idx_i)
         csr_reset_idx:                    rdata_mux = reset_r;
         csr_alloc_idx:                    rdata_mux = alloc_r;
         csr_base_idx:                     rdata_mux = base_r;
         csr_prof0_idx:                    rdata_mux = profile_i[31:0];
         csr_prof0_idx + csr_idx_t'(1):    rdata_mux = profile_i[63:32];
         csr_prof0_idx + csr_idx_t'(2):    rdata_mux = profile_i[95:64];
         csr_prof0_idx + csr_idx_t'(3):    rdata_mux = profile_i[127:96];
         default:                          rdata_mux = '0;
      endcase
   end

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         csr_rvalid_o <= 1'b0;
      end
      else
      begin
         csr_rvalid_o <= csr_re_i;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (csr_re_i)
      begin
         csr_rdata_o <= rdata_mux;
      end
   end

   assign dram_base_o = base_r;

   // low true run bit, so software can restart the core without
   // reloading the bitstream
   assign core_reset_o = !rst_n_i || !reset_r[0];

endmodule

`default_nettype wire

// ==== hw/dram_addr_xlate.sv ====
`default_nettype none

module dram_addr_xlate
(
   input  wire                        aclk_i,
   input  wire                        rst_n_i,
   input  wire                        dram_v_i,
   input  wire                        dram_we_i,
   input  wire bridge_pkg::bp_addr_t  dram_addr_i,
   input  wire bridge_pkg::csr_data_t dram_base_i,
   output logic                       dram_v_o,
   output logic                       dram_we_o,
   output bridge_pkg::dram_addr_t     dram_addr_o,
   output logic                       dram_over_limit_o
);

   import bridge_pkg::*;

   dram_addr_t dram_offset;
   dram_addr_t dram_addr_xlate;
   logic       over_limit;

   // the core dram base is a single bit, so xor strips it
   assign dram_offset = dram_addr_i ^ bp_dram_base;

   // then move into the block the OS allocated for us
   assign dram_addr_xlate = dram_offset + dram_base_i;

   // a program that runs past this has likely gone wrong
   assign over_limit = dram_v_i && (dram_offset >= mem_upper_limit);

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         dram_v_o          <= 1'b0;
         dram_over_limit_o <= 1'b0;
      end
      else
      begin
         dram_v_o          <= dram_v_i;
         dram_over_limit_o <= over_limit;
      end
   end

   // base is sampled together with the request, a later write does not
   // affect a request already in flight
   always_ff @(posedge aclk_i)
   begin
      if (dram_v_i)
      begin
         dram_we_o   <= dram_we_i;
         dram_addr_o <= dram_addr_xlate;
      end
   end

endmodule

`default_nettype wire

// ==== hw/host_addr_xlate.sv ====
`default_nettype none

module host_addr_xlate
(
   input  wire                       aclk_i,
   input  wire                       rst_n_i,
   input  wire                       host_v_i,
   input  wire                       host_we_i,
   input  wire bridge_pkg::ps_addr_t host_addr_i,
   output logic                      host_v_o,
   output logic                      host_we_o,
   output bridge_pkg::bp_addr_t      host_addr_o
);

   import bridge_pkg::*;

   bp_addr_t addr_xlate;

   // window 0x0000_0000 lands on core dram at 0x8000_0000
   // window 0x2000_0000 lands on core local space at 0
   // bit 28 of the window is not carried over, each window covers 256 MiB
   assign addr_xlate = {~host_addr_i[29], 3'b000, host_addr_i[27:0]};

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         host_v_o <= 1'b0;
      end
      else
      begin
         host_v_o <= host_v_i;
      end
   end

   // payload only moves with a valid command
   always_ff @(posedge aclk_i)
   begin
      if (host_v_i)
      begin
         host_we_o   <= host_we_i;
         host_addr_o <= addr_xlate;
      end
   end

endmodule

`default_nettype wire

// ==== hw/mem_profiler.sv ====
`default_nettype none

module mem_profiler
(
   input  wire                       aclk_i,
   input  wire                       rst_n_i,
   input  wire                       core_reset_i,
   input  wire                       req_v_i,
   input  wire bridge_pkg::bp_addr_t req_addr_i,
   output bridge_pkg::profile_t      profile_o
);

   import bridge_pkg::*;

   region_t  region;
   profile_t profile_r;

   // 8 MiB regions, the upper dram address bits are ignored
   assign region = req_addr_i[region_msb -: $bits(region_t)];

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         profile_r <= '0;
      end
      else if (core_reset_i)
      begin
         // a new program run starts with an empty map
         profile_r <= '0;
      end
      else if (req_v_i)
      begin
         profile_r[region] <= 1'b1;
      end
   end

   assign profile_o = profile_r;

endmodule

`default_nettype wire

// ==== tests/bridge_assert.sv ====
`default_nettype none

module bridge_assert
(
   input wire aclk_i,
   input wire rst_n_i,
   input wire reset_bit_i,
   input wire bp_reset_i,
   input wire host_v_i,
   input wire host_v_out_i,
   input wire dram_v_out_i,
   input wire over_limit_i
);

   timeunit 1ns;
   timeprecision 1ps;

   // number of assertion failures so far
   int unsigned failures = 0;

   // run bit low must keep the core in reset
   core_held: assert property (@(posedge aclk_i) !reset_bit_i |-> bp_reset_i)
      else
      begin
         failures++;
         $error("bp_reset_o low while the reset register bit is 0");
      end

   flag_with_valid: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      over_limit_i |-> dram_v_out_i)
      else
      begin
         failures++;
         $error("dram_over_limit_o high without dram_v_o");
      end

   // host stage has a fixed latency of one cycle
   host_latency: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      host_v_out_i == $past(host_v_i))
      else
      begin
         failures++;
         $error("host_v_o does not follow host_v_i by one cycle");
      end

endmodule

bind bridge_top bridge_assert u_bridge_assert
(
   .aclk_i       (aclk_i),
   .rst_n_i      (rst_n_i),
   .reset_bit_i  (u_csr_regs.reset_r[0]),
   .bp_reset_i   (bp_reset_o),
   .host_v_i     (host_v_i),
   .host_v_out_i (host_v_o),
   .dram_v_out_i (dram_v_o),
   .over_limit_i (dram_over_limit_o)
);

`default_nettype wire

// ==== tests/bridge_patterns.txt ====
// chain cmd arg0 arg1 exp0 exp1, chain 1 issues right after the previous command
// 1 host: we addr core_addr 0 / 2 dram: we addr dram_addr over / 3 csr wr: idx data bp_reset 0 / 4 csr rd: idx 0 data 0
0 4 0 0 00000000 0
1 4 1 0 00000000 0
1 4 2 0 00000000 0
0 4 3 0 00000000 0
1 4 4 0 00000000 0
0 4 5 0 00000000 0
1 4 6 0 00000000 0
0 4 7 0 00000000 0
0 1 1 00001000 80001000 0
1 1 0 20000040 00000040 0
1 1 0 32345678 02345678 0
0 1 0 1abcdef0 8abcdef0 0
0 3 2 10000000 1 0
1 4 2 0 10000000 0
1 2 1 80000000 10000000 0
0 2 1 877ffffc 177ffffc 0
1 2 0 87800000 17800000 1
0 3 0 1 0 0
1 2 1 80000100 10000100 0
0 2 0 80800000 10800000 0
1 2 1 8c000000 1c000000 1
0 2 0 90000000 20000000 1
0 2 1 a4000000 34000000 1
1 2 0 bf800000 4f800000 1
0 4 3 0 01000003 0
1 4 4 0 00000001 0
0 4 5 0 00000100 0
1 4 6 0 80000000 0
0 3 3 ffffffff 0 0
1 3 7 00001234 0 0
0 4 3 0 01000003 0
0 3 0 0 1 0
0 2 0 80800000 10800000 0
0 4 3 0 00000000 0
1 4 4 0 00000000 0
1 4 5 0 00000000 0
1 4 6 0 00000000 0
0 4 2 0 10000000 0

// ==== tests/bridge_tb.sv ====
`default_nettype none

module bridge_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import bridge_pkg::*;

   localparam int max_patterns = 64;
   localparam int fields = 6;

   // one response the DUT owes, flag_b marks a read on the register port
   typedef struct {
      int          due;
      logic        flag_a;
      logic        flag_b;
      logic [31:0] data;
   } expect_t;

   logic       aclk_i;
   logic       rst_n_i;
   logic       host_v_i;
   logic       host_we_i;
   ps_addr_t   host_addr_i;
   logic       host_v_o;
   logic       host_we_o;
   bp_addr_t   host_addr_o;
   logic       dram_v_i;
   logic       dram_we_i;
   bp_addr_t   dram_addr_i;
   logic       dram_v_o;
   logic       dram_we_o;
   dram_addr_t dram_addr_o;
   logic       dram_over_limit_o;
   logic       csr_we_i;
   logic       csr_re_i;
   csr_idx_t   csr_idx_i;
   csr_data_t  csr_wdata_i;
   logic       csr_rvalid_o;
   csr_data_t  csr_rdata_o;
   logic       bp_reset_o;

   logic [31:0] pattern_mem [0:max_patterns*fields-1];
   int          pattern_count;
   int          timeout_limit;
   int          cycle_count;
   logic [31:0] lfsr_state;
   expect_t     host_q[$];
   expect_t     dram_q[$];
   expect_t     csr_q[$];

   bridge_top dut (.*);

   initial
   begin
      aclk_i = 1'b0;
      forever #2 aclk_i = ~aclk_i;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_bp_addr(input string name, input bp_addr_t got, input bp_addr_t exp);
      if (got !== exp)
         abort_run($sformatf("Fail at %0t ns: %s got %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_dram_addr(input string name, input dram_addr_t got,
                                  input dram_addr_t exp);
      if (got !== exp)
         abort_run($sformatf("Fail at %0t ns: %s got %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_csr(input string name, input csr_data_t got, input csr_data_t exp);
      if (got !== exp)
         abort_run($sformatf("Fail at %0t ns: %s got %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("Fail at %0t ns: %s got %b, expected %b", $time, name, got, exp));
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic feedback;
      feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
      return {state[30:0], feedback};
   endfunction

   task automatic idle_inputs();
      host_v_i <= 1'b0;
      dram_v_i <= 1'b0;
      csr_we_i <= 1'b0;
      csr_re_i <= 1'b0;
   endtask

   // called on a rising edge, the DUT samples the command on the next one
   task automatic apply_command(input int base);
      logic [31:0] arg0;
      logic [31:0] arg1;
      expect_t     e;
      arg0 = pattern_mem[base+2];
      arg1 = pattern_mem[base+3];
      e.due = cycle_count + 2;
      e.flag_a = pattern_mem[base+4][0];
      e.flag_b = pattern_mem[base+5][0];
      e.data = pattern_mem[base+4];
      case (pattern_mem[base+1])
         32'd1:
         begin
            host_v_i <= 1'b1;
            host_we_i <= arg0[0];
            host_addr_i <= arg1[29:0];
            e.flag_a = arg0[0];
            host_q.push_back(e);
         end
         32'd2:
         begin
            dram_v_i <= 1'b1;
            dram_we_i <= arg0[0];
            dram_addr_i <= arg1;
            e.flag_a = arg0[0];
            dram_q.push_back(e);
         end
         32'd3:
         begin
            csr_we_i <= 1'b1;
            csr_idx_i <= arg0[2:0];
            csr_wdata_i <= arg1;
            e.flag_b = 1'b0;
            csr_q.push_back(e);
         end
         32'd4:
         begin
            csr_re_i <= 1'b1;
            csr_idx_i <= arg0[2:0];
            e.flag_b = 1'b1;
            csr_q.push_back(e);
         end
         default:
            abort_run($sformatf("unknown command code %0h in the pattern file",
                                pattern_mem[base+1]));
      endcase
   endtask

   // each output stream is either due this cycle or must stay idle
   task automatic check_outputs();
      expect_t e;
      if (host_q.size() > 0 && host_q[0].due == cycle_count)
      begin
         e = host_q.pop_front();
         check_bit("host_v_o", host_v_o, 1'b1);
         check_bit("host_we_o", host_we_o, e.flag_a);
         check_bp_addr("host_addr_o", host_addr_o, e.data);
      end
      else
         check_bit("host_v_o", host_v_o, 1'b0);
      if (dram_q.size() > 0 && dram_q[0].due == cycle_count)
      begin
         e = dram_q.pop_front();
         check_bit("dram_v_o", dram_v_o, 1'b1);
         check_bit("dram_we_o", dram_we_o, e.flag_a);
         check_dram_addr("dram_addr_o", dram_addr_o, e.data);
         check_bit("dram_over_limit_o", dram_over_limit_o, e.flag_b);
      end
      else
      begin
         check_bit("dram_v_o", dram_v_o, 1'b0);
         check_bit("dram_over_limit_o", dram_over_limit_o, 1'b0);
      end
      if (csr_q.size() > 0 && csr_q[0].due == cycle_count)
      begin
         e = csr_q.pop_front();
         check_bit("csr_rvalid_o", csr_rvalid_o, e.flag_b);
         if (e.flag_b)
            check_csr("csr_rdata_o", csr_rdata_o, e.data);
         else
            check_bit("bp_reset_o", bp_reset_o, e.flag_a);
      end
      else
         check_bit("csr_rvalid_o", csr_rvalid_o, 1'b0);
   endtask

   always @(negedge aclk_i)
   begin
      if (dut.u_bridge_assert.failures != 0)
         abort_run("an assertion bound to the DUT failed");
      if (rst_n_i)
         check_outputs();
   end

   always @(posedge aclk_i)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_limit)
         abort_run($sformatf("timeout, the run was still going after %0d cycles", cycle_count));
   end

   initial
   begin
      int         base;
      logic [1:0] gap;
      cycle_count = 0;
      timeout_limit = 1000;
      lfsr_state = 32'hec55_e6fd;
      rst_n_i = 1'b0;
      host_v_i = 1'b0;
      host_we_i = 1'b0;
      host_addr_i = '0;
      dram_v_i = 1'b0;
      dram_we_i = 1'b0;
      dram_addr_i = '0;
      csr_we_i = 1'b0;
      csr_re_i = 1'b0;
      csr_idx_i = '0;
      csr_wdata_i = '0;
      for (int i = 0; i < max_patterns*fields; i++)
         pattern_mem[i] = '0;
      $readmemh("tests/bridge_patterns.txt", pattern_mem);
      pattern_count = 0;
      while (pattern_count < max_patterns && pattern_mem[pattern_count*fields+1] != 0)
         pattern_count++;
      if (pattern_count == 0)
         abort_run("no commands found in tests/bridge_patterns.txt");
      // up to three idle cycles plus the command itself, and the drain at the end
      timeout_limit = 10 + 5*pattern_count + 40;

      repeat (10) @(posedge aclk_i);
      rst_n_i <= 1'b1;
      @(negedge aclk_i);
      check_bit("bp_reset_o", bp_reset_o, 1'b1);

      for (int p = 0; p < pattern_count; p++)
      begin
         base = p*fields;
         gap = 2'd0;
         if (pattern_mem[base] == 0)
         begin
            repeat (2)
            begin
               lfsr_state = lfsr_next(lfsr_state);
               gap = {gap[0], lfsr_state[0]};
            end
         end
         repeat (gap)
         begin
            @(posedge aclk_i);
            idle_inputs();
         end
         @(posedge aclk_i);
         idle_inputs();
         apply_command(base);
      end
      @(posedge aclk_i);
      idle_inputs();
      repeat (3) @(posedge aclk_i);
      @(negedge aclk_i);

      if (dut.u_bridge_assert.failures != 0)
         abort_run("an assertion bound to the DUT failed");
      if (host_q.size() == 0 && dram_q.size() == 0 && csr_q.size() == 0)
      begin
         $display("Test passed");
         $finish;
      end
      else
      begin
         abort_run("some responses never arrived before the end of the run");
      end
   end

endmodule

`default_nettype wire
